//--- tcb_lite.f
rtl/tcb_lite_pkg.sv
rtl/tcb_lite_if.sv
rtl/tcb_lite_arbiter.sv
rtl/tcb_lite_multiplexer.sv
rtl/tcb_lite_memory.sv
rtl/tcb_lite_subsystem.sv
verif/tcb_lite_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tcb_lite_tb \
    -f tcb_lite.f -o tcb_lite_sim \
    && ./obj_dir/tcb_lite_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

//--- verif/tcb_lite_tb.sv
module tcb_lite_tb;

    localparam int IFN    = 2;
    localparam int PERIOD = 40;
    localparam int LIMIT  = 4000;
    localparam int ADR    = tcb_lite_pkg::ADR;
    localparam int DAT    = tcb_lite_pkg::DAT;
    localparam int IDX    = $clog2(tcb_lite_pkg::MEM_DEPTH);
    localparam logic [ADR-1:0] OOR = ADR'(tcb_lite_pkg::MEM_DEPTH);

    logic                                  man;
    logic                                  rst_n;
    logic [IFN-1:0]                        vld;
    logic [IFN-1:0]                        rdy;
    logic [IFN-1:0]                        op;
    logic [IFN-1:0]                        err;
    logic [IFN-1:0][ADR-1:0]               adr;
    logic [IFN-1:0][tcb_lite_pkg::BYT-1:0] byt;
    logic [IFN-1:0][DAT-1:0]               wdt;
    logic [IFN-1:0][DAT-1:0]               rdt;

    // pending request per manager, held until granted
    logic                        req_vld [IFN];
    logic                        req_op  [IFN];
    logic [ADR-1:0]              req_adr [IFN];
    logic [tcb_lite_pkg::BYT-1:0] req_byt [IFN];
    logic [DAT-1:0]              req_wdt [IFN];

    // reference memory, round-robin pointer, responses in flight
    logic [DAT-1:0] ref_mem [tcb_lite_pkg::MEM_DEPTH];
    int             ptr_m;
    // grant seen on the ports in the last cycle
    int             last_grant;
    int             cycles = 0;
    logic [31:0]    lcg_state = 32'hc5b2;
    int             exp_mgr_q [$];
    logic           exp_rd_q  [$];
    logic [DAT-1:0] exp_rdt_q [$];
    logic           exp_err_q [$];

    tcb_lite_subsystem #(.IFN(IFN)) dut (
        .man   (man),
        .rst_n (rst_n),
        .vld   (vld),
        .rdy   (rdy),
        .op    (op),
        .adr   (adr),
        .byt   (byt),
        .wdt   (wdt),
        .rdt   (rdt),
        .err   (err)
    );

    always #(PERIOD / 2) man = ~man;

    // run limit
    always @(posedge man) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("** Error run did not finish within %0d cycles", LIMIT);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("** Error %s: %s expected %h actual %h", name, what, exp_v, act_v);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic set_req(input int m, input tcb_lite_pkg::tcb_op_e o, input logic [ADR-1:0] a,
                           input logic [tcb_lite_pkg::BYT-1:0] b, input logic [DAT-1:0] d);
        req_vld[m] = 1'b1;
        req_op[m]  = o;
        req_adr[m] = a;
        req_byt[m] = b;
        req_wdt[m] = d;
    endtask

    // first pending manager above the last winner, wrapping
    function automatic int next_grant();
        int idx;
        for (int i = 1; i <= IFN; i++) begin
            idx = (ptr_m + i) % IFN;
            if (req_vld[idx]) return idx;
        end
        return -1;
    endfunction

    task automatic check_response(input string name);
        int             g;
        logic           rd;
        logic [DAT-1:0] e_rdt;
        logic           e_err;
        g     = exp_mgr_q.pop_front();
        rd    = exp_rd_q.pop_front();
        e_rdt = exp_rdt_q.pop_front();
        e_err = exp_err_q.pop_front();
        for (int m = 0; m < IFN; m++) begin
            // write data on rdt is not defined, only reads are compared
            if (m != g || rd) begin
                check_value(name, $sformatf("rdt[%0d]", m), (m == g) ? e_rdt : '0, rdt[m]);
            end
            check_value(name, $sformatf("err[%0d]", m), 32'((m == g) && e_err), 32'(err[m]));
        end
    endtask

    // one clock from falling edge to falling edge
    task automatic run_cycle(input string name);
        int             g;
        int             exp_sel;
        logic           rd;
        logic [DAT-1:0] e_rdt;
        logic           e_err;
        for (int m = 0; m < IFN; m++) begin
            vld[m] = req_vld[m];
            op[m]  = req_op[m];
            adr[m] = req_adr[m];
            byt[m] = req_byt[m];
            wdt[m] = req_wdt[m];
        end
        g = next_grant();
        // arbiter is combinational, let it settle
        #(PERIOD / 4);
        // idle bus keeps the last winner selected
        exp_sel    = (g >= 0) ? g : ptr_m;
        last_grant = -1;
        for (int m = 0; m < IFN; m++) begin
            check_value(name, $sformatf("rdy[%0d]", m), (m == exp_sel) ? 32'd1 : 32'd0,
                        32'(rdy[m]));
            if (vld[m] && rdy[m]) begin
                last_grant = m;
            end
        end
        rd    = 1'b0;
        e_rdt = '0;
        e_err = 1'b0;
        if (g >= 0) begin
            rd = (req_op[g] == tcb_lite_pkg::OP_READ);
            if (req_adr[g] >= OOR) begin
                e_err = 1'b1;
            end else if (rd) begin
                e_rdt = ref_mem[req_adr[g][IDX-1:0]];
            end else begin
                // merge enabled lanes into the model
                for (int b = 0; b < tcb_lite_pkg::BYT; b++) begin
                    if (req_byt[g][b]) begin
                        ref_mem[req_adr[g][IDX-1:0]][8*b +: 8] = req_wdt[g][8*b +: 8];
                    end
                end
            end
            ptr_m      = g;
            req_vld[g] = 1'b0;
        end
        exp_mgr_q.push_back(g);
        exp_rd_q.push_back(rd);
        exp_rdt_q.push_back(e_rdt);
        exp_err_q.push_back(e_err);
        @(posedge man);
        @(negedge man);
        if (exp_mgr_q.size() >= tcb_lite_pkg::DLY) check_response(name);
    endtask

    task automatic drain(input string name);
        while (req_vld[0] || req_vld[1]) run_cycle(name);
        run_cycle(name);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        for (int m = 0; m < IFN; m++) req_vld[m] = 1'b0;
        vld = '0;
        repeat (3) @(posedge man);
        @(negedge man);
        check_value("reset", "rdy", 32'd0, 32'(rdy));
        check_value("reset", "err", 32'd0, 32'(err));
        rst_n = 1'b1;
        ptr_m = IFN - 1;
        exp_mgr_q.delete();
        exp_rd_q.delete();
        exp_rdt_q.delete();
        exp_err_q.delete();
        // rdy comes up on the next edge
        @(negedge man);
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic test_single_rw();
        logic [DAT-1:0] d;
        d = lcg_next();
        set_req(0, tcb_lite_pkg::OP_WRITE, 12'h010, 4'hf, d);
        run_cycle("single_rw");
        set_req(0, tcb_lite_pkg::OP_READ, 12'h010, 4'h0, '0);
        run_cycle("single_rw");
        check_value("single_rw", "grant", 32'd0, 32'(last_grant));
        check_value("single_rw", "rdt[0]", d, rdt[0]);
        run_cycle("single_rw");
    endtask

    task automatic test_byte_enable();
        logic [DAT-1:0] a;
        logic [DAT-1:0] b;
        a = lcg_next();
        b = lcg_next();
        set_req(0, tcb_lite_pkg::OP_WRITE, 12'h020, 4'hf, a);
        run_cycle("byte_enable");
        set_req(0, tcb_lite_pkg::OP_WRITE, 12'h020, 4'b0101, b);
        run_cycle("byte_enable");
        set_req(0, tcb_lite_pkg::OP_READ, 12'h020, 4'h0, '0);
        run_cycle("byte_enable");
        check_value("byte_enable", "rdt[0]", (a & 32'hff00ff00) | (b & 32'h00ff00ff), rdt[0]);
    endtask

    // both managers always pending, grants alternate from manager 0
    task automatic test_arbitration();
        int cnt [IFN];
        apply_reset();
        for (int m = 0; m < IFN; m++) cnt[m] = 0;
        for (int k = 0; k < 6; k++) begin
            for (int m = 0; m < IFN; m++) begin
                if (!req_vld[m]) begin
                    set_req(m, tcb_lite_pkg::OP_WRITE, ADR'(12'h100 + 16 * m + cnt[m]), 4'hf,
                            lcg_next());
                    cnt[m]++;
                end
            end
            run_cycle("arbitration");
            check_value("arbitration", "grant", 32'(k % 2), 32'(last_grant));
        end
        drain("arbitration");
    endtask

    task automatic test_response_routing();
        for (int k = 0; k < 6; k++) begin
            for (int m = 0; m < IFN; m++) begin
                if (!req_vld[m]) begin
                    set_req(m, tcb_lite_pkg::OP_READ, ADR'(12'h100 + 16 * m + k % 3),
                            4'h0, '0);
                end
            end
            run_cycle("response_routing");
        end
        drain("response_routing");
    endtask

    task automatic test_out_of_range();
        logic [DAT-1:0] d;
        d = lcg_next();
        // word 0 shares its low index bits with the first bad address
        set_req(1, tcb_lite_pkg::OP_WRITE, 12'h000, 4'hf, d);
        run_cycle("out_of_range");
        set_req(1, tcb_lite_pkg::OP_WRITE, OOR, 4'hf, ~d);
        run_cycle("out_of_range");
        check_value("out_of_range", "err[1]", 32'd1, 32'(err[1]));
        set_req(1, tcb_lite_pkg::OP_READ, 12'hfff, 4'h0, '0);
        run_cycle("out_of_range");
        check_value("out_of_range", "rdt[1]", 32'd0, rdt[1]);
        set_req(1, tcb_lite_pkg::OP_READ, 12'h000, 4'h0, '0);
        run_cycle("out_of_range");
        check_value("out_of_range", "rdt[1]", d, rdt[1]);
    endtask

    task automatic test_random_mix();
        int          issued;
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            set_req(i % IFN, tcb_lite_pkg::OP_WRITE, ADR'(12'h200 + i), 4'hf, lcg_next());
            run_cycle("random_fill");
        end
        issued = 0;
        while (issued < 200 || req_vld[0] || req_vld[1]) begin
            for (int m = 0; m < IFN; m++) begin
                r = lcg_next();
                if (!req_vld[m] && issued < 200 && r[31:30] != 2'b00) begin
                    // one in sixteen lands above the memory
                    set_req(m, tcb_lite_pkg::tcb_op_e'(r[17]),
                            (r[29:26] == 4'h0) ? ADR'(12'h400 + r[25:18])
                                               : ADR'(12'h200 + r[21:18]),
                            r[16:13], lcg_next());
                    issued++;
                end
            end
            run_cycle("random_mix");
        end
        run_cycle("random_mix");
    endtask

    initial begin
        man   = 1'b0;
        rst_n = 1'b0;
        vld   = '0;
        op    = '0;
        adr   = '0;
        byt   = '0;
        wdt   = '0;
        for (int m = 0; m < IFN; m++) set_req(m, tcb_lite_pkg::OP_READ, '0, '0, '0);
        apply_reset();
        test_single_rw();
        test_byte_enable();
        test_arbitration();
        test_response_routing();
        test_out_of_range();
        test_random_mix();
        $display("TESTS PASSED");
        $finish;
    end

endmodule : tcb_lite_tb

//--- rtl/tcb_lite_subsystem.sv
module tcb_lite_subsystem #(
    parameter int unsigned IFN = 2
) (
    input  logic                                    man,
    input  logic                                    rst_n,
    // handshake per manager
    input  logic [IFN-1:0]                          vld,
    output logic [IFN-1:0]                          rdy,
    // request per manager, op bit follows tcb_op_e
    input  logic [IFN-1:0]                          op,
    input  logic [IFN-1:0][tcb_lite_pkg::ADR-1:0]   adr,
    input  logic [IFN-1:0][tcb_lite_pkg::BYT-1:0]   byt,
    input  logic [IFN-1:0][tcb_lite_pkg::DAT-1:0]   wdt,
    // response per manager
    output logic [IFN-1:0][tcb_lite_pkg::DAT-1:0]   rdt,
    output logic [IFN-1:0]                          err
);

    localparam int unsigned IFL = (IFN > 1) ? $clog2(IFN) : 1;

    ////////////////////
    // buses and wires
    ////////////////////

    tcb_lite_if mgr_bus [IFN-1:0] (.man(man), .rst_n(rst_n));
    tcb_lite_if mem_bus (.man(man), .rst_n(rst_n));

    logic [IFN-1:0] bus_vld;
    logic [IFL-1:0] sel;
    logic           trn;

    // plain ports onto the manager bus array
    for (genvar i = 0; i < IFN; i++) begin : gen_port
        assign mgr_bus[i].vld = vld[i];
        assign mgr_bus[i].op  = tcb_lite_pkg::tcb_op_e'(op[i]);
        assign mgr_bus[i].adr = adr[i];
        assign mgr_bus[i].byt = byt[i];
        assign mgr_bus[i].wdt = wdt[i];
        assign rdy[i]         = mgr_bus[i].rdy;
        assign rdt[i]         = mgr_bus[i].rdt;
        assign err[i]         = mgr_bus[i].err;
        // arbiter request vector
        assign bus_vld[i]     = mgr_bus[i].vld;
    end : gen_port

    ////////////////////
    // instances
    ////////////////////

    tcb_lite_arbiter #(
        .IFN (IFN)
    ) u_arbiter (
        .man   (man),
        .rst_n (rst_n),
        .vld   (bus_vld),
        .sel   (sel),
        .trn   (trn)
    );

    tcb_lite_multiplexer #(
        .IFN (IFN)
    ) u_multiplexer (
        .man   (man),
        .rst_n (rst_n),
        .sel   (sel),
        .sub   (mgr_bus),
        .mem   (mem_bus),
        .trn   (trn)
    );

    tcb_lite_memory u_memory (
        .man   (man),
        .rst_n (rst_n),
        .bus   (mem_bus)
    );

endmodule : tcb_lite_subsystem

//--- rtl/tcb_lite_memory.sv
module tcb_lite_memory (
    input  logic    man,
    input  logic    rst_n,
    tcb_lite_if.rcv bus
);

    // word index width
    localparam int unsigned IDX = $clog2(tcb_lite_pkg::MEM_DEPTH);

    ////////////////////
    // storage
    ////////////////////

    logic [tcb_lite_pkg::DAT-1:0] mem [tcb_lite_pkg::MEM_DEPTH];

    logic           rdy_q;
    logic           trn;
    logic           in_range;
    logic [IDX-1:0] idx;

    ////////////////////
    // handshake
    ////////////////////

    // no wait states, low only until first edge out of reset
    always_ff @(posedge man) begin
        if (!rst_n) begin
            rdy_q <= 1'b0;
        end else begin
            rdy_q <= 1'b1;
        end
    end

    assign bus.rdy = rdy_q;
    assign trn     = bus.vld & rdy_q;

    // adr counts words, upper bits select nothing
    assign in_range = (bus.adr < tcb_lite_pkg::ADR'(tcb_lite_pkg::MEM_DEPTH));
    assign idx      = bus.adr[IDX-1:0];

    ////////////////////
    // write
    ////////////////////

    // byte lanes updated per byt bit
    always_ff @(posedge man) begin
        if (trn && in_range && (bus.op == tcb_lite_pkg::OP_WRITE)) begin
            for (int b = 0; b < tcb_lite_pkg::BYT; b++) begin
                if (bus.byt[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdt[8*b +: 8];
                end
            end
        end
    end

    ////////////////////
    // response
    ////////////////////

    // one register stage gives the DLY of 1
    always_ff @(posedge man) begin
        if (!rst_n) begin
            bus.rdt <= '0;
            bus.err <= 1'b0;
        end else begin
            // zero outside the response cycle
            bus.rdt <= '0;
            bus.err <= trn && !in_range;
            if (trn && in_range && (bus.op == tcb_lite_pkg::OP_READ)) begin
                bus.rdt <= mem[idx];
            end
        end
    end

    // read data must be defined, catches reads of never written words
    a_rdt_known : assert property (
        @(posedge bus.man) disable iff (!bus.rst_n)
        trn |-> ##(tcb_lite_pkg::DLY) !$isunknown(bus.rdt)
    ) else $error("memory response has unknown bits");

endmodule : tcb_lite_memory

//--- rtl/tcb_lite_multiplexer.sv
module tcb_lite_multiplexer #(
    parameter int unsigned IFN = 2
) (
    input  logic                                         man,
    input  logic                                         rst_n,
    input  logic [((IFN > 1) ? $clog2(IFN) : 1)-1:0]     sel,
    tcb_lite_if.rcv                                      sub [IFN-1:0],
    tcb_lite_if.drv                                      mem,
    output logic                                         trn
);

    localparam int unsigned IFL = (IFN > 1) ? $clog2(IFN) : 1;

    ////////////////////
    // request gather
    ////////////////////

    // flat arrays, an interface array takes no dynamic index
    logic                           vld_a [IFN];
    tcb_lite_pkg::tcb_op_e          op_a  [IFN];
    logic [tcb_lite_pkg::ADR-1:0]   adr_a [IFN];
    logic [tcb_lite_pkg::BYT-1:0]   byt_a [IFN];
    logic [tcb_lite_pkg::DAT-1:0]   wdt_a [IFN];

    // response steering select, sel delayed by DLY
    logic [IFL-1:0] sel_dly [tcb_lite_pkg::DLY];
    logic [IFL-1:0] rsp_sel;

    for (genvar i = 0; i < IFN; i++) begin : gen_req
        assign vld_a[i] = sub[i].vld;
        assign op_a[i]  = sub[i].op;
        assign adr_a[i] = sub[i].adr;
        assign byt_a[i] = sub[i].byt;
        assign wdt_a[i] = sub[i].wdt;
    end : gen_req

    // selected manager onto the memory side
    assign mem.vld = vld_a[sel];
    assign mem.op  = op_a[sel];
    assign mem.adr = adr_a[sel];
    assign mem.byt = byt_a[sel];
    assign mem.wdt = wdt_a[sel];

    // transfer strobe back to arbiter
    assign trn = mem.vld & mem.rdy;

    ////////////////////
    // response delay
    ////////////////////

    // free running shift, stage k holds sel of k+1 cycles ago
    always_ff @(posedge man) begin
        if (!rst_n) begin
            for (int k = 0; k < tcb_lite_pkg::DLY; k++) begin
                sel_dly[k] <= '0;
            end
        end else begin
            sel_dly[0] <= sel;
            for (int k = 1; k < tcb_lite_pkg::DLY; k++) begin
                sel_dly[k] <= sel_dly[k-1];
            end
        end
    end

    assign rsp_sel = sel_dly[tcb_lite_pkg::DLY-1];

    ////////////////////
    // response and rdy fan-out
    ////////////////////

    for (genvar i = 0; i < IFN; i++) begin : gen_rsp
        // only the granted manager sees rdy
        assign sub[i].rdy = (sel == IFL'(i)) ? mem.rdy : 1'b0;
        // others read zero
        assign sub[i].rdt = (rsp_sel == IFL'(i)) ? mem.rdt : '0;
        assign sub[i].err = (rsp_sel == IFL'(i)) ? mem.err : 1'b0;
    end : gen_rsp

    ////////////////////
    // checks
    ////////////////////

    // stalled request must hold, for memory wait states later on
    a_req_stable : assert property (
        @(posedge mem.man) disable iff (!mem.rst_n)
        (mem.vld && !mem.rdy) |=> mem.vld && $stable({mem.op, mem.adr, mem.byt, mem.wdt})
    ) else $error("request on memory side changed while stalled");

endmodule : tcb_lite_multiplexer

//--- rtl/tcb_lite_arbiter.sv
module tcb_lite_arbiter #(
    parameter int unsigned IFN = 2
) (
    input  logic                                         man,
    input  logic                                         rst_n,
    input  logic [IFN-1:0]                               vld,
    output logic [((IFN > 1) ? $clog2(IFN) : 1)-1:0]     sel,
    input  logic                                         trn
);

    // select width, one bit minimum for a single manager
    localparam int unsigned IFL = (IFN > 1) ? $clog2(IFN) : 1;

    ////////////////////
    // priority pointer
    ////////////////////

    // last winner, search starts one above it
    logic [IFL-1:0] ptr;

    // reset to the top index so manager 0 goes first
    always_ff @(posedge man) begin
        if (!rst_n) begin
            ptr <= IFL'(IFN - 1);
        end else if (trn) begin
            // record winner only on a real transfer
            ptr <= sel;
        end
    end

    ////////////////////
    // round-robin search
    ////////////////////

    always_comb begin
        int unsigned idx;
        logic        found;
        // nothing valid: keep pointing at last winner
        sel   = ptr;
        found = 1'b0;
        idx   = 0;
        // walk upward from ptr+1, wrap, ptr itself last
        for (int unsigned i = 1; i <= IFN; i++) begin
            idx = (int'(ptr) + i) % IFN;
            if (!found && vld[idx]) begin
                sel   = IFL'(idx);
                found = 1'b1;
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // grant only goes to a requesting manager
    a_sel_valid : assert property (
        @(posedge man) disable iff (!rst_n)
        (|vld) |-> vld[sel]
    ) else $error("arbiter selected manager %0d without vld", sel);

endmodule : tcb_lite_arbiter

//--- rtl/tcb_lite_if.sv
interface tcb_lite_if (
    input logic man,
    input logic rst_n
);

    ////////////////////
    // handshake
    ////////////////////

    // transfer when both high in one cycle
    logic vld;
    logic rdy;

    ////////////////////
    // request
    ////////////////////

    tcb_lite_pkg::tcb_op_e          op;
    logic [tcb_lite_pkg::ADR-1:0]   adr;
    logic [tcb_lite_pkg::BYT-1:0]   byt;
    logic [tcb_lite_pkg::DAT-1:0]   wdt;

    ////////////////////
    // response
    ////////////////////

    // valid DLY cycles after the transfer, no valid bit of its own
    logic [tcb_lite_pkg::DAT-1:0]   rdt;
    logic                           err;

    // manager side
    modport drv (
        input  man, rst_n,
        output vld, op, adr, byt, wdt,
        input  rdy, rdt, err
    );

    // subordinate side
    modport rcv (
        input  man, rst_n,
        input  vld, op, adr, byt, wdt,
        output rdy, rdt, err
    );

endinterface : tcb_lite_if

//--- rtl/tcb_lite_pkg.sv
package tcb_lite_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    // address width, adr is a word address
    localparam int unsigned ADR = 12;

    // data width
    localparam int unsigned DAT = 32;

    // one enable bit per byte lane
    localparam int unsigned BYT = DAT / 8;

    ////////////////////
    // timing and sizing
    ////////////////////

    // response delay in cycles after the transfer
    localparam int unsigned DLY = 1;

    // implemented words
    // word addresses at or above this are out of range
    localparam int unsigned MEM_DEPTH = 1024;

    ////////////////////
    // access opcode
    ////////////////////

    // one bit on the bus
    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } tcb_op_e;

endpackage : tcb_lite_pkg
